// File: rtl/cfg_ctrl_pkg.sv
`default_nettype none

package cfg_ctrl_pkg;

	//////////////////////////////////////////////////
	// Widths and address map
	//////////////////////////////////////////////////
	localparam int DATA_W        = 32;
	localparam int ADDR_W        = 32;
	localparam int FABRIC_ADDR_W = 15;	// Target side address bits
	localparam int PAGE_W        = 20;
	localparam int OFFSET_W      = 12;	// 4 KiB pages
	localparam int SEL_W         = 5;
	localparam int N_TARGETS     = 4;
	localparam int STRB_W        = DATA_W / 8;

	localparam logic [PAGE_W-1:0] DEF_BASE_PAGE = 20'h30000;

	// Page order follows the enum, local page sits right after the last one
	typedef enum logic [$clog2(N_TARGETS)-1:0] {
		TGT_USER_PRJ,
		TGT_LOGIC_ANLZ,
		TGT_STREAM_BRIDGE,
		TGT_IO_SERDES
	} tgt_idx_e;

	typedef logic [N_TARGETS-1:0] tgt_en_t;

	//////////////////////////////////////////////////
	// Bundles
	//////////////////////////////////////////////////
	typedef struct packed {
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} cfg_req_t;

	typedef struct packed {
		logic                     awvalid;
		logic [FABRIC_ADDR_W-1:0] awaddr;
		logic                     wvalid;
		logic [DATA_W-1:0]        wdata;
		logic [STRB_W-1:0]        wstrb;
		logic                     arvalid;
		logic [FABRIC_ADDR_W-1:0] araddr;
		logic                     rready;
	} axil_m_t;

	typedef struct packed {
		logic              awready;
		logic              wready;
		logic              arready;
		logic [DATA_W-1:0] rdata;
		logic              rvalid;
	} axil_s_t;

	typedef struct packed {
		logic              awvalid;
		logic [ADDR_W-1:0] awaddr;
		logic              wvalid;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] wstrb;
		logic              arvalid;
		logic [ADDR_W-1:0] araddr;
		logic              rready;
	} host_req_t;

	typedef struct packed {
		logic              awready;
		logic              wready;
		logic              arready;
		logic [DATA_W-1:0] rdata;
		logic              rvalid;
	} host_rsp_t;

	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] sel;
	} wb_req_t;

endpackage

`default_nettype wire

// File: rtl/wb_host_port.sv
`timescale 1ns/1ps
`default_nettype none

module wb_host_port import cfg_ctrl_pkg::*; (
	input  wire               axi_clk,
	input  wire               axi_reset_n,
	input  wire wb_req_t      wb_req_i,
	output logic              wb_ack_o,
	output logic [DATA_W-1:0] wb_rdata_o,
	output logic              req_valid_o,
	input  wire               req_ready_i,
	output cfg_req_t          req_o,
	input  wire               rsp_valid_i,
	input  wire [DATA_W-1:0]  rsp_rdata_i
);

	typedef enum logic {WB_IDLE, WB_BUSY} wb_state_e;

	wb_state_e state_q;
	logic      capture;

	// No new cycle while the previous ack is still on the bus
	assign capture = (state_q == WB_IDLE) && !wb_ack_o && wb_req_i.cyc && wb_req_i.stb;

	always_ff @(posedge axi_clk) begin
		if (capture) begin
			req_o.we    <= wb_req_i.we;
			req_o.addr  <= wb_req_i.adr;
			req_o.wdata <= wb_req_i.wdata;	// Byte selects dropped
		end
		if (rsp_valid_i && state_q == WB_BUSY)
			wb_rdata_o <= rsp_rdata_i;	// Zero for writes
	end

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state_q     <= WB_IDLE;
			req_valid_o <= 1'b0;
			wb_ack_o    <= 1'b0;
		end else begin
			wb_ack_o <= 1'b0;
			case (state_q)
				WB_IDLE: begin
					if (capture) begin
						req_valid_o <= 1'b1;
						state_q     <= WB_BUSY;
					end
				end
				WB_BUSY: begin
					if (req_valid_o && req_ready_i)
						req_valid_o <= 1'b0;	// Taken by the arbiter
					if (rsp_valid_i) begin
						wb_ack_o <= 1'b1;
						state_q  <= WB_IDLE;
					end
				end
				default: state_q <= WB_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/axil_host_port.sv
`timescale 1ns/1ps
`default_nettype none

module axil_host_port import cfg_ctrl_pkg::*; (
	input  wire              axi_clk,
	input  wire              axi_reset_n,
	input  wire host_req_t   host_req_i,
	output host_rsp_t        host_rsp_o,
	output logic             req_valid_o,
	input  wire              req_ready_i,
	output cfg_req_t         req_o,
	input  wire              rsp_valid_i,
	input  wire [DATA_W-1:0] rsp_rdata_i
);

	typedef enum logic [2:0] {
		H_IDLE,
		H_RD_WAIT,
		H_RD_HOLD,
		H_WR_DATA,
		H_WR_WAIT
	} host_state_e;

	host_state_e       state_q;
	logic              awready_q;
	logic              wready_q;
	logic              arready_q;
	logic              rvalid_q;
	logic [DATA_W-1:0] rdata_q;
	logic              aw_take;
	logic              ar_take;
	logic              w_take;

	// Write wins over read when both show up in idle
	assign aw_take = (state_q == H_IDLE) && host_req_i.awvalid;
	assign ar_take = (state_q == H_IDLE) && !host_req_i.awvalid && host_req_i.arvalid;
	assign w_take  = (state_q == H_WR_DATA) && host_req_i.wvalid;

	always_comb begin
		host_rsp_o.awready = awready_q;
		host_rsp_o.wready  = wready_q;	// Doubles as write completion
		host_rsp_o.arready = arready_q;
		host_rsp_o.rdata   = rdata_q;
		host_rsp_o.rvalid  = rvalid_q;
	end

	always_ff @(posedge axi_clk) begin
		if (aw_take)
			req_o.addr <= host_req_i.awaddr;
		if (ar_take) begin
			req_o.addr <= host_req_i.araddr;
			req_o.we   <= 1'b0;
		end
		if (w_take) begin
			req_o.wdata <= host_req_i.wdata;
			req_o.we    <= 1'b1;
		end
		if (rsp_valid_i && state_q == H_RD_WAIT)
			rdata_q <= rsp_rdata_i;	// Held until rready
	end

	//////////////////////////////////////////////////
	// Host channel FSM
	//////////////////////////////////////////////////
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state_q     <= H_IDLE;
			req_valid_o <= 1'b0;
			awready_q   <= 1'b0;
			wready_q    <= 1'b0;
			arready_q   <= 1'b0;
			rvalid_q    <= 1'b0;
		end else begin
			awready_q <= 1'b0;
			wready_q  <= 1'b0;
			arready_q <= 1'b0;
			if (req_valid_o && req_ready_i)
				req_valid_o <= 1'b0;
			case (state_q)
				H_IDLE: begin
					if (aw_take) begin
						awready_q <= 1'b1;
						state_q   <= H_WR_DATA;
					end else if (ar_take) begin
						arready_q   <= 1'b1;
						req_valid_o <= 1'b1;
						state_q     <= H_RD_WAIT;
					end
				end
				H_RD_WAIT: begin
					if (rsp_valid_i) begin
						rvalid_q <= 1'b1;
						state_q  <= H_RD_HOLD;
					end
				end
				H_RD_HOLD: begin
					if (host_req_i.rready) begin
						rvalid_q <= 1'b0;
						state_q  <= H_IDLE;
					end
				end
				H_WR_DATA: begin
					if (w_take) begin
						req_valid_o <= 1'b1;
						state_q     <= H_WR_WAIT;
					end
				end
				H_WR_WAIT: begin
					if (rsp_valid_i) begin
						wready_q <= 1'b1;
						state_q  <= H_IDLE;
					end
				end
				default: state_q <= H_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module req_arbiter import cfg_ctrl_pkg::*; (
	input  wire               axi_clk,
	input  wire               axi_reset_n,
	input  wire               wb_valid_i,
	output logic              wb_ready_o,
	input  wire cfg_req_t     wb_req_i,
	input  wire               host_valid_i,
	output logic              host_ready_o,
	input  wire cfg_req_t     host_req_i,
	output logic              m_valid_o,
	input  wire               m_ready_i,
	output cfg_req_t          m_req_o,
	input  wire               rsp_valid_i,
	input  wire [DATA_W-1:0]  rsp_rdata_i,
	output logic              wb_rsp_valid_o,
	output logic              host_rsp_valid_o,
	output logic [DATA_W-1:0] rsp_rdata_o
);

	logic grant_host_q;	// Low selects Wishbone
	logic outstanding_q;
	logic accept;
	logic other_req;

	assign m_valid_o    = grant_host_q ? host_valid_i : wb_valid_i;
	assign m_req_o      = grant_host_q ? host_req_i : wb_req_i;
	assign wb_ready_o   = !grant_host_q && m_ready_i;
	assign host_ready_o = grant_host_q && m_ready_i;
	assign accept       = m_valid_o && m_ready_i;
	assign other_req    = grant_host_q ? wb_valid_i : host_valid_i;

	// Grant is frozen while a request is in flight, so it still names the owner
	assign wb_rsp_valid_o   = rsp_valid_i && !grant_host_q;
	assign host_rsp_valid_o = rsp_valid_i && grant_host_q;
	assign rsp_rdata_o      = rsp_rdata_i;

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			grant_host_q  <= 1'b0;
			outstanding_q <= 1'b0;
		end else begin
			if (accept)
				outstanding_q <= 1'b1;
			else if (rsp_valid_i)
				outstanding_q <= 1'b0;
			if (!outstanding_q && !m_valid_o && other_req)
				grant_host_q <= !grant_host_q;	// Sticky, moves only on idle owner
		end
	end

endmodule

`default_nettype wire

// File: rtl/axil_master.sv
`timescale 1ns/1ps
`default_nettype none

module axil_master import cfg_ctrl_pkg::*; (
	input  wire               axi_clk,
	input  wire               axi_reset_n,
	input  wire               req_valid_i,
	output logic              req_ready_o,
	input  wire cfg_req_t     req_i,
	output logic              rsp_valid_o,
	output logic [DATA_W-1:0] rsp_rdata_o,
	output axil_m_t           fabric_o,
	input  wire axil_s_t      fabric_i,
	output logic [PAGE_W-1:0] cur_page_o
);

	typedef enum logic [2:0] {
		M_IDLE,
		M_RD_ADDR,
		M_RD_DATA,
		M_WR_BOTH,
		M_WR_DATA
	} m_state_e;

	m_state_e state_q;
	logic     aw_hs;
	logic     w_hs;
	logic     ar_hs;
	logic     r_hs;

	assign aw_hs = fabric_o.awvalid && fabric_i.awready;
	assign w_hs  = fabric_o.wvalid && fabric_i.wready;
	assign ar_hs = fabric_o.arvalid && fabric_i.arready;
	assign r_hs  = fabric_o.rready && fabric_i.rvalid;

	assign req_ready_o = (state_q == M_IDLE);	// One access at a time

	//////////////////////////////////////////////////
	// Master FSM
	//////////////////////////////////////////////////
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state_q     <= M_IDLE;
			fabric_o    <= '0;
			rsp_valid_o <= 1'b0;
			rsp_rdata_o <= '0;
			cur_page_o  <= '1;	// Parks on a sink page
		end else begin
			rsp_valid_o <= 1'b0;
			case (state_q)
				M_IDLE: begin
					if (req_valid_i) begin
						cur_page_o <= req_i.addr[OFFSET_W +: PAGE_W];
						if (req_i.we) begin
							fabric_o.awvalid <= 1'b1;
							fabric_o.awaddr  <= req_i.addr[FABRIC_ADDR_W-1:0];
							fabric_o.wvalid  <= 1'b1;
							fabric_o.wdata   <= req_i.wdata;
							fabric_o.wstrb   <= '1;	// Full word writes only
							state_q          <= M_WR_BOTH;
						end else begin
							fabric_o.arvalid <= 1'b1;
							fabric_o.araddr  <= req_i.addr[FABRIC_ADDR_W-1:0];
							fabric_o.rready  <= 1'b1;
							state_q          <= M_RD_ADDR;
						end
					end
				end
				M_RD_ADDR: begin
					if (ar_hs) begin
						fabric_o.arvalid <= 1'b0;
						if (r_hs) begin
							// Data in the same cycle, as the local page and sink do
							fabric_o.rready <= 1'b0;
							rsp_rdata_o     <= fabric_i.rdata;
							rsp_valid_o     <= 1'b1;
							state_q         <= M_IDLE;
						end else begin
							state_q <= M_RD_DATA;
						end
					end
				end
				M_RD_DATA: begin
					if (r_hs) begin
						fabric_o.rready <= 1'b0;
						rsp_rdata_o     <= fabric_i.rdata;
						rsp_valid_o     <= 1'b1;
						state_q         <= M_IDLE;
					end
				end
				M_WR_BOTH: begin
					if (w_hs)
						fabric_o.wvalid <= 1'b0;	// Data may finish first
					if (aw_hs) begin
						fabric_o.awvalid <= 1'b0;
						if (w_hs || !fabric_o.wvalid) begin
							rsp_rdata_o <= '0;
							rsp_valid_o <= 1'b1;
							state_q     <= M_IDLE;
						end else begin
							state_q <= M_WR_DATA;
						end
					end
				end
				M_WR_DATA: begin
					if (w_hs) begin
						fabric_o.wvalid <= 1'b0;
						rsp_rdata_o     <= '0;
						rsp_valid_o     <= 1'b1;
						state_q         <= M_IDLE;
					end
				end
				default: state_q <= M_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/target_router.sv
`timescale 1ns/1ps
`default_nettype none

module target_router import cfg_ctrl_pkg::*; #(
	parameter logic [PAGE_W-1:0] BASE_PAGE = DEF_BASE_PAGE
) (
	input  wire                          axi_clk,
	input  wire                          axi_reset_n,
	input  wire [PAGE_W-1:0]             cur_page_i,
	input  wire axil_m_t                 fabric_i,
	input  wire axil_s_t [N_TARGETS-1:0] target_rsp_i,
	output axil_s_t                      merged_o,
	output tgt_en_t                      target_en_o,
	output logic [SEL_W-1:0]             user_prj_sel_o
);

	localparam int IDX_W = $clog2(N_TARGETS);

	logic [PAGE_W-1:0] page_off;
	logic              hit_tgt;
	logic              hit_local;
	logic              self_ans;
	logic              local_wr;
	tgt_idx_e          tgt_sel;

	//////////////////////////////////////////////////
	// Page decode
	//////////////////////////////////////////////////
	assign page_off  = cur_page_i - BASE_PAGE;	// Below base wraps high, so sink
	assign hit_tgt   = page_off < PAGE_W'(N_TARGETS);
	assign hit_local = page_off == PAGE_W'(N_TARGETS);
	assign self_ans  = !hit_tgt;	// Local page or sink
	assign tgt_sel   = tgt_idx_e'(page_off[IDX_W-1:0]);

	always_comb begin
		target_en_o = '0;
		if (hit_tgt)
			target_en_o[tgt_sel] = 1'b1;
	end

	//////////////////////////////////////////////////
	// Response merge
	//////////////////////////////////////////////////
	always_comb begin
		merged_o.awready = self_ans && fabric_i.awvalid;
		merged_o.wready  = self_ans && fabric_i.wvalid;
		merged_o.arready = self_ans && fabric_i.arvalid;
		merged_o.rvalid  = self_ans && fabric_i.arvalid;	// Read data with the address
		if (hit_local)
			merged_o.rdata = DATA_W'(user_prj_sel_o);
		else if (self_ans)
			merged_o.rdata = '1;
		else
			merged_o.rdata = '0;
		for (int i = 0; i < N_TARGETS; i++) begin
			if (target_en_o[i]) begin
				merged_o.awready = merged_o.awready | target_rsp_i[i].awready;
				merged_o.wready  = merged_o.wready | target_rsp_i[i].wready;
				merged_o.arready = merged_o.arready | target_rsp_i[i].arready;
				merged_o.rvalid  = merged_o.rvalid | target_rsp_i[i].rvalid;
				merged_o.rdata   = merged_o.rdata | target_rsp_i[i].rdata;
			end
		end
	end

	// Local page takes both write channels in one cycle
	assign local_wr = hit_local && fabric_i.awvalid && fabric_i.wvalid &&
		(fabric_i.awaddr[OFFSET_W-1:0] == '0) && fabric_i.wstrb[0];

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n)
			user_prj_sel_o <= '0;
		else if (local_wr)
			user_prj_sel_o <= fabric_i.wdata[SEL_W-1:0];
	end

endmodule

`default_nettype wire

// File: rtl/cfg_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_ctrl_top import cfg_ctrl_pkg::*; #(
	parameter logic [PAGE_W-1:0] BASE_PAGE = DEF_BASE_PAGE
) (
	input  wire                          axi_clk,
	input  wire                          axi_reset_n,
	input  wire wb_req_t                 wb_req_i,
	output logic                         wb_ack_o,
	output logic [DATA_W-1:0]            wb_rdata_o,
	input  wire host_req_t               host_req_i,
	output host_rsp_t                    host_rsp_o,
	output axil_m_t                      fabric_o,
	input  wire axil_s_t [N_TARGETS-1:0] target_rsp_i,
	output tgt_en_t                      target_en_o,
	output logic [SEL_W-1:0]             user_prj_sel_o
);

	// Host side request channels
	logic              wb_valid;
	logic              wb_ready;
	cfg_req_t          wb_cfg_req;
	logic              host_valid;
	logic              host_ready;
	cfg_req_t          host_cfg_req;

	// Arbiter to master
	logic              m_valid;
	logic              m_ready;
	cfg_req_t          m_req;
	logic              m_rsp_valid;
	logic [DATA_W-1:0] m_rsp_rdata;
	logic              wb_rsp_valid;
	logic              host_rsp_valid;
	logic [DATA_W-1:0] rsp_rdata;

	// Fabric side
	axil_s_t           merged;
	logic [PAGE_W-1:0] cur_page;

	wb_host_port i_wb_host_port (
		.axi_clk, .axi_reset_n,
		.wb_req_i, .wb_ack_o, .wb_rdata_o,
		.req_valid_o (wb_valid),     .req_ready_i (wb_ready), .req_o (wb_cfg_req),
		.rsp_valid_i (wb_rsp_valid), .rsp_rdata_i (rsp_rdata)
	);

	axil_host_port i_axil_host_port (
		.axi_clk, .axi_reset_n,
		.host_req_i, .host_rsp_o,
		.req_valid_o (host_valid),     .req_ready_i (host_ready), .req_o (host_cfg_req),
		.rsp_valid_i (host_rsp_valid), .rsp_rdata_i (rsp_rdata)
	);

	req_arbiter i_req_arbiter (
		.axi_clk, .axi_reset_n,
		.wb_valid_i   (wb_valid),   .wb_ready_o   (wb_ready),   .wb_req_i   (wb_cfg_req),
		.host_valid_i (host_valid), .host_ready_o (host_ready), .host_req_i (host_cfg_req),
		.m_valid_o    (m_valid),    .m_ready_i    (m_ready),    .m_req_o    (m_req),
		.rsp_valid_i  (m_rsp_valid), .rsp_rdata_i (m_rsp_rdata),
		.wb_rsp_valid_o (wb_rsp_valid), .host_rsp_valid_o (host_rsp_valid),
		.rsp_rdata_o  (rsp_rdata)
	);

	axil_master i_axil_master (
		.axi_clk, .axi_reset_n,
		.req_valid_i (m_valid),     .req_ready_o (m_ready),  .req_i (m_req),
		.rsp_valid_o (m_rsp_valid), .rsp_rdata_o (m_rsp_rdata),
		.fabric_o,   .fabric_i (merged),
		.cur_page_o  (cur_page)
	);

	target_router #(.BASE_PAGE(BASE_PAGE)) i_target_router (
		.axi_clk, .axi_reset_n,
		.cur_page_i  (cur_page), .fabric_i (fabric_o), .target_rsp_i,
		.merged_o    (merged),
		.target_en_o, .user_prj_sel_o
	);

endmodule

`default_nettype wire

// File: bench/target_model.sv
`timescale 1ns/1ps
`default_nettype none

module target_model import cfg_ctrl_pkg::*; (
	input  wire          axi_clk,
	input  wire          axi_reset_n,
	input  wire          en_i,
	input  wire axil_m_t fabric_i,
	output axil_s_t      rsp_o
);

	logic [DATA_W-1:0] mem [16];
	axil_s_t           rsp_q;
	logic [1:0]        wdly;
	logic [1:0]        ardly;
	logic [1:0]        rdly;
	logic              rd_pend;
	logic              wr_fire;
	logic              ar_fire;

	// Both write channels are taken in the same cycle
	assign wr_fire = en_i && fabric_i.awvalid && fabric_i.wvalid && !rsp_q.awready && wdly == 0;
	assign ar_fire = en_i && fabric_i.arvalid && !rsp_q.arready && !rd_pend &&
		!rsp_q.rvalid && ardly == 0;
	assign rsp_o   = en_i ? rsp_q : '0;	// Silent unless selected

	initial begin
		for (int i = 0; i < 16; i++)
			mem[i] = '0;
	end

	always_ff @(posedge axi_clk) begin
		if (wr_fire)
			mem[fabric_i.awaddr[5:2]] <= fabric_i.wdata;
	end

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			rsp_q   <= '0;
			wdly    <= '0;
			ardly   <= '0;
			rdly    <= '0;
			rd_pend <= 1'b0;
		end else begin
			rsp_q.awready <= 1'b0;
			rsp_q.wready  <= 1'b0;
			rsp_q.arready <= 1'b0;
			if (rsp_q.rvalid && fabric_i.rready)
				rsp_q.rvalid <= 1'b0;
			if (wr_fire) begin
				rsp_q.awready <= 1'b1;
				rsp_q.wready  <= 1'b1;
				wdly          <= 2'($urandom_range(3, 0));	// Delay for the next write
			end else if (en_i && fabric_i.awvalid && wdly != 0)
				wdly <= wdly - 2'd1;
			if (ar_fire) begin
				rsp_q.arready <= 1'b1;
				rd_pend       <= 1'b1;
				rdly          <= 2'($urandom_range(3, 0));
				ardly         <= 2'($urandom_range(3, 0));
			end else if (en_i && fabric_i.arvalid && !rd_pend && ardly != 0)
				ardly <= ardly - 2'd1;
			if (rd_pend) begin
				if (rdly == 0) begin
					rsp_q.rvalid <= 1'b1;
					rsp_q.rdata  <= mem[fabric_i.araddr[5:2]];
					rd_pend      <= 1'b0;
				end else
					rdly <= rdly - 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/cfg_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_ctrl_tb import cfg_ctrl_pkg::*; ();

	localparam int TIMEOUT = 500;

	typedef struct packed {
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} acc_t;

	logic                    axi_clk;
	logic                    axi_reset_n;
	wb_req_t                 wb_req;
	logic                    wb_ack_o;
	logic [DATA_W-1:0]       wb_rdata_o;
	host_req_t               host_req;
	host_rsp_t               host_rsp_o;
	axil_m_t                 fabric_o;
	axil_s_t [N_TARGETS-1:0] tgt_rsp;
	tgt_en_t                 target_en_o;
	logic [SEL_W-1:0]        user_prj_sel_o;

	// Expected state follows completion order and thus fabric order
	logic [N_TARGETS-1:0][15:0][DATA_W-1:0] shadow;
	logic [SEL_W-1:0]                       sel_shadow;
	acc_t                                   wb_q[$];
	acc_t                                   host_q[$];
	string                                  test_name;
	logic                                   check_addr;
	logic [ADDR_W-1:0]                      cur_addr;

	cfg_ctrl_top i_cfg_ctrl_top (
		.axi_clk, .axi_reset_n,
		.wb_req_i (wb_req), .wb_ack_o, .wb_rdata_o,
		.host_req_i (host_req), .host_rsp_o,
		.fabric_o, .target_rsp_i (tgt_rsp),
		.target_en_o, .user_prj_sel_o
	);

	for (genvar i = 0; i < N_TARGETS; i++) begin : g_tgt
		target_model i_target_model (
			.axi_clk, .axi_reset_n, .en_i (target_en_o[i]),
			.fabric_i (fabric_o), .rsp_o (tgt_rsp[i])
		);
	end

	always #50 axi_clk = !axi_clk;

	//////////////////////////////////////////////////
	// Reference model and compares
	//////////////////////////////////////////////////
	function automatic int page_index(input logic [ADDR_W-1:0] addr);
		logic [PAGE_W-1:0] off;
		off = addr[OFFSET_W +: PAGE_W] - DEF_BASE_PAGE;
		return (off <= PAGE_W'(N_TARGETS)) ? int'(off) : -1;	// 4 is the local page
	endfunction

	function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr,
		input logic [N_TARGETS-1:0][15:0][DATA_W-1:0] words, input logic [SEL_W-1:0] sel);
		int idx;
		idx = page_index(addr);
		if (idx >= 0 && idx < N_TARGETS)
			return words[idx][addr[5:2]];
		if (idx == N_TARGETS)
			return DATA_W'(sel);
		return '1;	// Sink and anything off the map
	endfunction

	function automatic tgt_en_t expected_en(input logic [ADDR_W-1:0] addr);
		int idx;
		idx = page_index(addr);
		return (idx >= 0 && idx < N_TARGETS) ? tgt_en_t'(1 << idx) : '0;
	endfunction

	task automatic abort_run(input string msg);
		$display("Error: %s", msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		if (exp !== act) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	task automatic check_sel(input string name, input logic [SEL_W-1:0] exp,
		input logic [SEL_W-1:0] act);
		if (exp !== act) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	task automatic check_en(input string name, input tgt_en_t exp, input tgt_en_t act);
		if (exp !== act) begin
			$display("Mismatch %s: expected %b, actual %b", name, exp, act);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	task automatic finish_access(input acc_t a, input logic [DATA_W-1:0] rdata);
		int idx;
		idx = page_index(a.addr);
		if (a.we) begin
			if (idx >= 0 && idx < N_TARGETS)
				shadow[idx][a.addr[5:2]] = a.data;
			else if (idx == N_TARGETS && a.addr[OFFSET_W-1:0] == '0)
				sel_shadow = a.data[SEL_W-1:0];
		end else
			check_data(test_name, expected_read(a.addr, shadow, sel_shadow), rdata);
		check_sel(test_name, sel_shadow, user_prj_sel_o);
	endtask

	//////////////////////////////////////////////////
	// Comparison process sampling just after the edge
	//////////////////////////////////////////////////
	always begin : compare
		logic              prev_rv;
		logic [DATA_W-1:0] prev_rd;
		acc_t              a;
		@(posedge axi_clk);
		#1;
		if (axi_reset_n) begin
			// rready seen here is the value the DUT sampled at this edge
			if (prev_rv && !host_req.rready) begin
				if (!host_rsp_o.rvalid)
					abort_run("host rvalid dropped before rready");
				check_data("rdata hold", prev_rd, host_rsp_o.rdata);
			end
			if (wb_ack_o) begin
				if (wb_q.size() == 0)
					abort_run("Wishbone ack without a pending cycle");
				a = wb_q.pop_front();
				finish_access(a, wb_rdata_o);
			end
			if (host_rsp_o.wready || (host_rsp_o.rvalid && !prev_rv)) begin
				if (host_q.size() == 0 || host_q[0].we != host_rsp_o.wready)
					abort_run("host completion does not match the oldest host access");
				a = host_q.pop_front();
				finish_access(a, host_rsp_o.rdata);
			end
			if (check_addr && (fabric_o.awvalid || fabric_o.arvalid)) begin
				check_en(test_name, expected_en(cur_addr), target_en_o);
				check_data(test_name, DATA_W'(cur_addr[FABRIC_ADDR_W-1:0]),
					DATA_W'(fabric_o.awvalid ? fabric_o.awaddr : fabric_o.araddr));
			end
		end
		prev_rv = host_rsp_o.rvalid;
		prev_rd = host_rsp_o.rdata;
	end

	//////////////////////////////////////////////////
	// Host side drivers
	//////////////////////////////////////////////////
	task automatic step_wait(inout int n, input string what);
		@(negedge axi_clk);
		n++;
		if (n > TIMEOUT)
			abort_run({"timeout waiting for ", what});
	endtask

	task automatic wb_access(input logic we, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		int n;
		@(negedge axi_clk);
		wb_q.push_back(acc_t'{we, addr, data});
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, wdata: data, sel: '1};
		n = 0;
		do
			step_wait(n, "Wishbone ack");
		while (!wb_ack_o);
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
	endtask

	task automatic host_access(input logic we, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data, input int stall);
		int n;
		@(negedge axi_clk);
		host_q.push_back(acc_t'{we, addr, data});
		n = 0;
		if (we) begin
			host_req.awvalid = 1'b1;
			host_req.awaddr  = addr;
			host_req.wvalid  = 1'b1;
			host_req.wdata   = data;
			host_req.wstrb   = '1;
			while (!host_rsp_o.awready)
				step_wait(n, "host awready");
			host_req.awvalid = 1'b0;
			while (!host_rsp_o.wready)
				step_wait(n, "host write completion");
			host_req.wvalid = 1'b0;
		end else begin
			host_req.arvalid = 1'b1;
			host_req.araddr  = addr;
			host_req.rready  = (stall == 0);
			while (!host_rsp_o.arready)
				step_wait(n, "host arready");
			host_req.arvalid = 1'b0;
			while (!host_rsp_o.rvalid)
				step_wait(n, "host rvalid");
			repeat (stall) @(negedge axi_clk);	// Back-pressure stretch
			host_req.rready = 1'b1;
			while (host_rsp_o.rvalid)
				step_wait(n, "host rvalid to drop");
			host_req.rready = 1'b0;
		end
	endtask

	function automatic logic [ADDR_W-1:0] random_addr();
		int kind;
		kind = $urandom_range(0, 6);
		if (kind == N_TARGETS && $urandom_range(0, 1) == 0)
			return {DEF_BASE_PAGE + PAGE_W'(kind), 12'h0};
		if (kind == 6)
			return {20'h00001, 12'(4 * $urandom_range(0, 15))};	// Off the map
		return {DEF_BASE_PAGE + PAGE_W'(kind), 12'(4 * $urandom_range(0, 15))};
	endfunction

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	initial begin : stimulus
		logic [ADDR_W-1:0] addr;
		int                n;
		void'($urandom(32'hbccf1817));
		axi_clk     = 1'b0;
		axi_reset_n = 1'b0;
		wb_req      = '0;
		host_req    = '0;
		shadow      = '0;
		sel_shadow  = '0;
		check_addr  = 1'b0;
		cur_addr    = '0;
		test_name   = "reset";
		repeat (10) @(negedge axi_clk);
		axi_reset_n = 1'b1;
		@(negedge axi_clk);
		check_data(test_name, '0, DATA_W'({fabric_o.awvalid, fabric_o.wvalid,
			fabric_o.arvalid, wb_ack_o, host_rsp_o.rvalid, host_rsp_o.wready}));
		check_en(test_name, '0, target_en_o);
		check_sel(test_name, '0, user_prj_sel_o);

		check_addr = 1'b1;
		test_name  = "target pages";
		for (int p = 0; p < N_TARGETS; p++) begin
			cur_addr = {DEF_BASE_PAGE + PAGE_W'(p), 12'(4 * $urandom_range(0, 15))};
			wb_access(1'b1, cur_addr, $urandom);
			wb_access(1'b0, cur_addr, '0);
			host_access(1'b1, cur_addr, $urandom, 0);
			host_access(1'b0, cur_addr, '0, 0);
		end

		test_name = "local page";
		cur_addr  = {DEF_BASE_PAGE + PAGE_W'(N_TARGETS), 12'h0};
		wb_access(1'b1, cur_addr, $urandom);
		host_access(1'b0, cur_addr, '0, 0);
		host_access(1'b1, cur_addr, $urandom, 0);
		wb_access(1'b0, cur_addr, '0);

		test_name = "sink";
		cur_addr  = {DEF_BASE_PAGE + 20'h5, 12'h010};
		wb_access(1'b0, cur_addr, '0);
		wb_access(1'b1, cur_addr, $urandom);
		cur_addr = 32'h8000_0000;
		host_access(1'b0, cur_addr, '0, 0);
		host_access(1'b1, cur_addr, $urandom, 0);
		check_addr = 1'b0;

		test_name = "random";
		fork
			repeat (150) begin
				addr = random_addr();
				wb_access(1'($urandom_range(0, 1)), addr, $urandom);
			end
			repeat (150) begin : host_thread
				logic [ADDR_W-1:0] haddr;
				haddr = random_addr();
				host_access(1'($urandom_range(0, 1)), haddr, $urandom,
					($urandom_range(0, 1) == 0) ? 0 : $urandom_range(1, 6));
			end
		join

		n = 0;
		while (wb_q.size() != 0 || host_q.size() != 0)
			step_wait(n, "outstanding accesses to drain");
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
rtl/cfg_ctrl_pkg.sv
rtl/wb_host_port.sv
rtl/axil_host_port.sv
rtl/req_arbiter.sv
rtl/axil_master.sv
rtl/target_router.sv
rtl/cfg_ctrl_top.sv
bench/target_model.sv
bench/cfg_ctrl_tb.sv

// File: run.sh
#!/bin/bash
# Build and run the testbench, the exit status is the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f compile.f --top-module cfg_ctrl_tb -o cfg_ctrl_sim \
	&& ./obj_dir/cfg_ctrl_sim \
	|| exit 1
